//--- sim.f
hw/mem_bus_pkg.sv
hw/bus_front.sv
hw/byte_sequencer.sv
hw/device_select.sv
hw/byte_ram.sv
hw/status_regs.sv
hw/mem_bus_top.sv
verification/mem_bus_tb.sv

//--- Makefile
SRCS := $(shell cat sim.f)

.PHONY: run clean

run: obj_dir/Vmem_bus_tb
	./obj_dir/Vmem_bus_tb

obj_dir/Vmem_bus_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module mem_bus_tb -f sim.f

clean:
	rm -rf obj_dir

//--- verification/mem_bus_tb.sv
`timescale 1ns/1ps

module mem_bus_tb;
  import mem_bus_pkg::*;

  localparam int unsigned RAM_ADDR_W  = 12;
  // Small RAM window the tests stay inside
  localparam int unsigned WIN_W       = 6;
  localparam int unsigned WIN_BYTES   = 1 << WIN_W;
  localparam int unsigned ACK_TIMEOUT = 100;
  localparam int unsigned NUM_RANDOM  = 200;

  logic  clk;
  logic  reset;
  logic  req;
  addr_t addr;
  data_t wdata;
  size_e size;
  logic  write;
  logic  ack;
  data_t rdata;
  data_t hex;
  data_t test_pass;

  // Reference model of the RAM window and both status words
  byte_t ram_model [0:WIN_BYTES-1];
  data_t hex_model;
  data_t pass_model;

  mem_bus_top #(
    .RAM_ADDR_W (RAM_ADDR_W)
  ) u_dut (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_req       (req),
    .i_addr      (addr),
    .i_wdata     (wdata),
    .i_size      (size),
    .i_write     (write),
    .o_ack       (ack),
    .o_rdata     (rdata),
    .o_hex       (hex),
    .o_test_pass (test_pass)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    assert (actual === expected) else
      abort_run($sformatf("error at %0t: %s expected %h, actual %h",
                          $time, name, expected, actual));
  endtask

  function automatic int unsigned size_bytes(input size_e sz);
    case (sz)
      SIZE_HALF: return 2;
      SIZE_WORD: return 4;
      default:   return 1;
    endcase
  endfunction

  // Model lookup where unmapped reads as zero
  function automatic byte_t model_read_byte(input addr_t a);
    addr_t off;
    byte_t b;
    b = '0;
    if (a - RAM_BASE < WIN_BYTES) begin
      off = a - RAM_BASE;
      b = ram_model[off[WIN_W-1:0]];
    end else if (a - REGS_BASE < 8) begin
      off = a - REGS_BASE;
      // Offsets 0..3 are the display word and 4..7 the test-pass word
      if (off[2]) b = byte_t'(pass_model >> {off[1:0], 3'b000});
      else b = byte_t'(hex_model >> {off[1:0], 3'b000});
    end
    return b;
  endfunction

  // Model update that drops unmapped writes
  task automatic model_write_byte(input addr_t a, input byte_t b);
    addr_t off;
    data_t mask;
    if (a - RAM_BASE < WIN_BYTES) begin
      off = a - RAM_BASE;
      ram_model[off[WIN_W-1:0]] = b;
    end else if (a - REGS_BASE < 8) begin
      off = a - REGS_BASE;
      mask = data_t'(8'hFF) << {off[1:0], 3'b000};
      if (off[2]) pass_model = (pass_model & ~mask) | (data_t'(b) << {off[1:0], 3'b000});
      else hex_model = (hex_model & ~mask) | (data_t'(b) << {off[1:0], 3'b000});
    end
  endtask

  // One four-phase access
  // Hold is the number of extra cycles req stays up after ack
  task automatic bus_access(input addr_t a, input data_t wd, input size_e sz,
                            input logic wr, input int unsigned hold, output data_t rd);
    int unsigned cnt;
    @(posedge clk);
    req   <= 1'b1;
    addr  <= a;
    wdata <= wd;
    size  <= sz;
    write <= wr;
    cnt = 0;
    @(negedge clk);
    while (!ack && cnt < ACK_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!ack) abort_run("timeout: o_ack never rose after i_req was raised");
    rd = rdata;
    // Ack and data frozen under back-pressure
    repeat (hold) begin
      @(negedge clk);
      check_value("o_ack", 32'd1, {31'd0, ack});
      check_value("o_rdata", rd, rdata);
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    // Req low but not yet sampled so ack is still up
    check_value("o_ack", 32'd1, {31'd0, ack});
    cnt = 0;
    while (ack && cnt < ACK_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (ack) abort_run("timeout: o_ack never fell after i_req was dropped");
  endtask

  // Access plus model update and checks
  task automatic checked_access(input addr_t a, input data_t wd, input size_e sz,
                                input logic wr, input int unsigned hold);
    data_t expected;
    data_t rd;
    int unsigned n;
    n = size_bytes(sz);
    expected = '0;
    // Byte k in lane k with upper lanes zero
    for (int unsigned k = 0; k < n; k++) begin
      expected = expected | (data_t'(model_read_byte(a + addr_t'(k))) << (8 * k));
    end
    bus_access(a, wd, sz, wr, hold, rd);
    if (wr) begin
      for (int unsigned k = 0; k < n; k++) begin
        model_write_byte(a + addr_t'(k), byte_t'(wd >> (8 * k)));
      end
    end else begin
      check_value("o_rdata", expected, rd);
    end
    check_value("o_hex", hex_model, hex);
    check_value("o_test_pass", pass_model, test_pass);
  endtask

  // Past the RAM, past the bank, or far away
  function automatic addr_t unmapped_addr();
    addr_t a;
    case ($urandom_range(0, 2))
      0: a = (addr_t'(1) << RAM_ADDR_W) + addr_t'($urandom_range(0, 60));
      1: a = REGS_BASE + 32'd8 + addr_t'($urandom_range(0, 4));
      default: a = 32'h8000_0000 + addr_t'($urandom_range(0, 255));
    endcase
    return a;
  endfunction

  task automatic random_access();
    addr_t a;
    size_e sz;
    int unsigned n;
    logic wr;
    case ($urandom_range(0, 2))
      0: sz = SIZE_BYTE;
      1: sz = SIZE_HALF;
      default: sz = SIZE_WORD;
    endcase
    n = size_bytes(sz);
    wr = ($urandom_range(0, 1) == 1);
    // Whole access stays inside one region
    case ($urandom_range(0, 4))
      0, 1: a = RAM_BASE + addr_t'($urandom_range(0, WIN_BYTES - n));
      2, 3: a = REGS_BASE + addr_t'($urandom_range(0, 8 - n));
      default: a = unmapped_addr();
    endcase
    checked_access(a, $urandom(), sz, wr, $urandom_range(0, 4));
  endtask

  initial begin
    addr_t a;
    void'($urandom(30));
    reset <= 1'b1;
    req   <= 1'b0;
    addr  <= '0;
    wdata <= '0;
    size  <= SIZE_BYTE;
    write <= 1'b0;
    hex_model  = '0;
    pass_model = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("o_ack", 32'd0, {31'd0, ack});
    check_value("o_hex", 32'd0, hex);
    check_value("o_test_pass", 32'd0, test_pass);

    // Fill the RAM window with a pattern from the whole address
    for (int unsigned w = 0; w < WIN_BYTES; w += 4) begin
      a = RAM_BASE + addr_t'(w);
      checked_access(a, (a * 32'h0101_0101) ^ 32'h5AC3_96E1, SIZE_WORD, 1'b1, 0);
    end

    // Word write then word read
    checked_access(RAM_BASE + 32'h20, 32'hA1B2_C3D4, SIZE_WORD, 1'b1, 1);
    checked_access(RAM_BASE + 32'h20, '0, SIZE_WORD, 1'b0, 3);

    // Sub-word merge and narrow reads
    checked_access(RAM_BASE + 32'h21, 32'h0000_00AB, SIZE_BYTE, 1'b1, 0);
    checked_access(RAM_BASE + 32'h22, 32'h0000_9F8E, SIZE_HALF, 1'b1, 0);
    checked_access(RAM_BASE + 32'h20, '0, SIZE_WORD, 1'b0, 0);
    checked_access(RAM_BASE + 32'h23, '0, SIZE_BYTE, 1'b0, 2);
    checked_access(RAM_BASE + 32'h21, '0, SIZE_HALF, 1'b0, 0);

    // Full and partial writes to the status bank
    checked_access(REGS_BASE, 32'h1234_5678, SIZE_WORD, 1'b1, 0);
    checked_access(REGS_BASE + 32'd4, 32'hC0DE_600D, SIZE_WORD, 1'b1, 2);
    checked_access(REGS_BASE + 32'd1, 32'h0000_00A5, SIZE_BYTE, 1'b1, 0);
    checked_access(REGS_BASE + 32'd6, 32'h0000_BEEF, SIZE_HALF, 1'b1, 1);
    checked_access(REGS_BASE, '0, SIZE_WORD, 1'b0, 1);
    checked_access(REGS_BASE + 32'd4, '0, SIZE_WORD, 1'b0, 0);
    // Half-word across the two words
    checked_access(REGS_BASE + 32'd3, '0, SIZE_HALF, 1'b0, 0);

    // Unmapped writes dropped and reads zero
    checked_access(32'h0000_1000, 32'hDEAD_BEEF, SIZE_WORD, 1'b1, 0);
    checked_access(REGS_BASE + 32'd8, 32'hFFFF_FFFF, SIZE_WORD, 1'b1, 1);
    checked_access(32'h8000_0000, 32'h0F0F_0F0F, SIZE_HALF, 1'b1, 0);
    checked_access(32'h0000_1000, '0, SIZE_WORD, 1'b0, 0);
    checked_access(REGS_BASE + 32'd8, '0, SIZE_WORD, 1'b0, 0);
    checked_access(32'h8000_0000, '0, SIZE_BYTE, 1'b0, 2);
    // Low RAM would show an aliased write
    checked_access(RAM_BASE, '0, SIZE_WORD, 1'b0, 0);

    repeat (NUM_RANDOM) random_access();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- hw/mem_bus_top.sv
`timescale 1ns/1ps

module mem_bus_top #(
  parameter int unsigned RAM_ADDR_W = 12
) (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_req,
  input  mem_bus_pkg::addr_t i_addr,
  input  mem_bus_pkg::data_t i_wdata,
  input  mem_bus_pkg::size_e i_size,
  input  logic               i_write,
  output logic               o_ack,
  output mem_bus_pkg::data_t o_rdata,
  output mem_bus_pkg::data_t o_hex,
  output mem_bus_pkg::data_t o_test_pass
);
  import mem_bus_pkg::*;

  // Front end to sequencer
  logic  start;
  addr_t acc_addr;
  data_t acc_wdata;
  size_e acc_size;
  logic  acc_write;
  logic  finish;
  data_t word;

  // Sequencer to decoder
  logic  strobe;
  addr_t byte_addr;
  byte_t wbyte;
  logic  byte_write;
  logic  done;
  byte_t rbyte;

  // Decoder to devices
  logic  ram_strobe;
  logic  regs_strobe;
  addr_t dev_addr;
  byte_t dev_wbyte;
  logic  dev_write;
  logic  ram_done;
  byte_t ram_rbyte;
  logic  regs_done;
  byte_t regs_rbyte;

  bus_front u_front (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_req    (i_req),
    .i_addr   (i_addr),
    .i_wdata  (i_wdata),
    .i_size   (i_size),
    .i_write  (i_write),
    .o_ack    (o_ack),
    .o_rdata  (o_rdata),
    .i_finish (finish),
    .i_word   (word),
    .o_start  (start),
    .o_addr   (acc_addr),
    .o_wdata  (acc_wdata),
    .o_size   (acc_size),
    .o_write  (acc_write)
  );

  byte_sequencer u_seq (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_start     (start),
    .i_addr      (acc_addr),
    .i_wdata     (acc_wdata),
    .i_size      (acc_size),
    .i_write     (acc_write),
    .o_finish    (finish),
    .o_word      (word),
    .i_done      (done),
    .i_rbyte     (rbyte),
    .o_strobe    (strobe),
    .o_byte_addr (byte_addr),
    .o_wbyte     (wbyte),
    .o_write     (byte_write)
  );

  device_select #(
    .RAM_ADDR_W (RAM_ADDR_W)
  ) u_sel (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_strobe      (strobe),
    .i_byte_addr   (byte_addr),
    .i_wbyte       (wbyte),
    .i_write       (byte_write),
    .o_done        (done),
    .o_rbyte       (rbyte),
    .i_ram_done    (ram_done),
    .i_ram_rbyte   (ram_rbyte),
    .i_regs_done   (regs_done),
    .i_regs_rbyte  (regs_rbyte),
    .o_ram_strobe  (ram_strobe),
    .o_regs_strobe (regs_strobe),
    .o_dev_addr    (dev_addr),
    .o_dev_wbyte   (dev_wbyte),
    .o_dev_write   (dev_write)
  );

  // Devices see only their own offset bits
  byte_ram #(
    .RAM_ADDR_W (RAM_ADDR_W)
  ) u_ram (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_strobe (ram_strobe),
    .i_addr   (dev_addr[RAM_ADDR_W-1:0]),
    .i_wbyte  (dev_wbyte),
    .i_write  (dev_write),
    .o_rbyte  (ram_rbyte),
    .o_done   (ram_done)
  );

  status_regs u_regs (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_strobe    (regs_strobe),
    .i_addr      (dev_addr[REGS_ADDR_W-1:0]),
    .i_wbyte     (dev_wbyte),
    .i_write     (dev_write),
    .o_rbyte     (regs_rbyte),
    .o_done      (regs_done),
    .o_hex       (o_hex),
    .o_test_pass (o_test_pass)
  );

endmodule

//--- hw/status_regs.sv
`timescale 1ns/1ps

module status_regs (
  input  logic                               i_clk,
  input  logic                               i_reset,
  input  logic                               i_strobe,
  input  logic [mem_bus_pkg::REGS_ADDR_W-1:0] i_addr,
  input  mem_bus_pkg::byte_t                 i_wbyte,
  input  logic                               i_write,
  output mem_bus_pkg::byte_t                 o_rbyte,
  output logic                               o_done,
  output mem_bus_pkg::data_t                 o_hex,
  output mem_bus_pkg::data_t                 o_test_pass
);
  import mem_bus_pkg::*;

  localparam int unsigned NUM_REGS = 1 << REGS_ADDR_W;

  byte_t regs_q [0:NUM_REGS-1];

  // Byte writes, whole bank cleared on reset
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
      o_done <= 1'b0;
    end else begin
      o_done <= i_strobe;
      if (i_strobe && i_write) begin
        regs_q[i_addr] <= i_wbyte;
      end
    end
  end

  // Read byte lines up with done
  always_ff @(posedge i_clk) begin
    if (i_strobe) begin
      o_rbyte <= regs_q[i_addr];
    end
  end

  // Offsets 0..3 display, 4..7 test pass, little-endian
  assign o_hex       = {regs_q[3], regs_q[2], regs_q[1], regs_q[0]};
  assign o_test_pass = {regs_q[7], regs_q[6], regs_q[5], regs_q[4]};

endmodule

//--- hw/byte_ram.sv
`timescale 1ns/1ps

module byte_ram #(
  parameter int unsigned RAM_ADDR_W = 12
) (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_strobe,
  input  logic [RAM_ADDR_W-1:0] i_addr,
  input  mem_bus_pkg::byte_t    i_wbyte,
  input  logic                  i_write,
  output mem_bus_pkg::byte_t    o_rbyte,
  output logic                  o_done
);
  import mem_bus_pkg::*;

  localparam int unsigned DEPTH = 1 << RAM_ADDR_W;

  byte_t mem [0:DEPTH-1];

  // Single port, read-before-write
  always_ff @(posedge i_clk) begin
    if (i_strobe) begin
      if (i_write) begin
        mem[i_addr] <= i_wbyte;
      end
      o_rbyte <= mem[i_addr];
    end
  end

  // Fixed one-cycle response
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_done <= 1'b0;
    end else begin
      o_done <= i_strobe;
    end
  end

endmodule

//--- hw/device_select.sv
`timescale 1ns/1ps

module device_select #(
  parameter int unsigned RAM_ADDR_W = 12
) (
  input  logic               i_clk,
  input  logic               i_reset,
  // Byte transfer from the sequencer
  input  logic               i_strobe,
  input  mem_bus_pkg::addr_t i_byte_addr,
  input  mem_bus_pkg::byte_t i_wbyte,
  input  logic               i_write,
  output logic               o_done,
  output mem_bus_pkg::byte_t o_rbyte,
  // Device responses
  input  logic               i_ram_done,
  input  mem_bus_pkg::byte_t i_ram_rbyte,
  input  logic               i_regs_done,
  input  mem_bus_pkg::byte_t i_regs_rbyte,
  // Shared device request
  output logic               o_ram_strobe,
  output logic               o_regs_strobe,
  output mem_bus_pkg::addr_t o_dev_addr,
  output mem_bus_pkg::byte_t o_dev_wbyte,
  output logic               o_dev_write
);
  import mem_bus_pkg::*;

  // Keep only the bits above each window
  localparam addr_t RAM_MASK  = ~((addr_t'(1) << RAM_ADDR_W) - addr_t'(1));
  localparam addr_t REGS_MASK = ~((addr_t'(1) << REGS_ADDR_W) - addr_t'(1));

  typedef enum logic [1:0] {
    RGN_NONE,
    RGN_RAM,
    RGN_REGS
  } region_e;

  region_e region_q;
  logic    ram_hit;
  logic    regs_hit;
  // Own response for an unmapped address
  logic    miss_done_q;

  assign ram_hit  = (i_byte_addr & RAM_MASK) == RAM_BASE;
  assign regs_hit = (i_byte_addr & REGS_MASK) == REGS_BASE;

  assign o_ram_strobe  = i_strobe & ram_hit;
  assign o_regs_strobe = i_strobe & regs_hit;
  assign o_dev_addr    = i_byte_addr;
  assign o_dev_wbyte   = i_wbyte;
  assign o_dev_write   = i_write;

  // Remember who got the strobe
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      region_q    <= RGN_NONE;
      miss_done_q <= 1'b0;
    end else begin
      miss_done_q <= i_strobe & ~ram_hit & ~regs_hit;
      if (i_strobe) begin
        if (ram_hit) begin
          region_q <= RGN_RAM;
        end else if (regs_hit) begin
          region_q <= RGN_REGS;
        end else begin
          region_q <= RGN_NONE;
        end
      end
    end
  end

  // Steer back the strobed device, zero byte when unmapped
  always_comb begin
    o_done  = miss_done_q;
    o_rbyte = '0;
    case (region_q)
      RGN_RAM: begin
        o_done  = i_ram_done;
        o_rbyte = i_ram_rbyte;
      end
      RGN_REGS: begin
        o_done  = i_regs_done;
        o_rbyte = i_regs_rbyte;
      end
      default: ;
    endcase
  end

endmodule

//--- hw/byte_sequencer.sv
`timescale 1ns/1ps

module byte_sequencer (
  input  logic               i_clk,
  input  logic               i_reset,
  // Access from the front end
  input  logic               i_start,
  input  mem_bus_pkg::addr_t i_addr,
  input  mem_bus_pkg::data_t i_wdata,
  input  mem_bus_pkg::size_e i_size,
  input  logic               i_write,
  output logic               o_finish,
  output mem_bus_pkg::data_t o_word,
  // Byte transfers to the decoder
  input  logic               i_done,
  input  mem_bus_pkg::byte_t i_rbyte,
  output logic               o_strobe,
  output mem_bus_pkg::addr_t o_byte_addr,
  output mem_bus_pkg::byte_t o_wbyte,
  output logic               o_write
);
  import mem_bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT
  } state_e;

  state_e     state_q;
  addr_t      addr_q;
  data_t      wdata_q;
  logic       write_q;
  // Current byte lane
  logic [1:0] lane_q;
  // Bytes still to go after this one
  logic [1:0] remain_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q  <= ST_IDLE;
      o_finish <= 1'b0;
      lane_q   <= 2'd0;
      remain_q <= 2'd0;
    end else begin
      o_finish <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (i_start) begin
            lane_q   <= 2'd0;
            remain_q <= size_last_lane(i_size);
            state_q  <= ST_ISSUE;
          end
        end
        // Strobe is up for exactly this one cycle
        ST_ISSUE: state_q <= ST_WAIT;
        ST_WAIT: begin
          if (i_done) begin
            if (remain_q == 2'd0) begin
              o_finish <= 1'b1;
              state_q  <= ST_IDLE;
            end else begin
              remain_q <= remain_q - 2'd1;
              lane_q   <= lane_q + 2'd1;
              state_q  <= ST_ISSUE;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Address walk and read assembly
  always_ff @(posedge i_clk) begin
    if (state_q == ST_IDLE && i_start) begin
      addr_q  <= i_addr;
      wdata_q <= i_wdata;
      write_q <= i_write;
      // Unused upper lanes read as zero
      o_word  <= '0;
    end else if (state_q == ST_WAIT && i_done) begin
      addr_q <= addr_q + addr_t'(1);
      // Little-endian, byte k lands in lane k
      if (!write_q) begin
        o_word[{lane_q, 3'b000} +: 8] <= i_rbyte;
      end
    end
  end

  assign o_strobe    = (state_q == ST_ISSUE);
  assign o_byte_addr = addr_q;
  assign o_wbyte     = wdata_q[{lane_q, 3'b000} +: 8];
  assign o_write     = write_q;

endmodule

//--- hw/bus_front.sv
`timescale 1ns/1ps

module bus_front (
  input  logic               i_clk,
  input  logic               i_reset,
  // Processor side, four-phase
  input  logic               i_req,
  input  mem_bus_pkg::addr_t i_addr,
  input  mem_bus_pkg::data_t i_wdata,
  input  mem_bus_pkg::size_e i_size,
  input  logic               i_write,
  output logic               o_ack,
  output mem_bus_pkg::data_t o_rdata,
  // Sequencer side
  input  logic               i_finish,
  input  mem_bus_pkg::data_t i_word,
  output logic               o_start,
  output mem_bus_pkg::addr_t o_addr,
  output mem_bus_pkg::data_t o_wdata,
  output mem_bus_pkg::size_e o_size,
  output logic               o_write
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_ACK
  } state_e;

  state_e state_q;

  // Handshake FSM
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q <= ST_IDLE;
      o_start <= 1'b0;
    end else begin
      // Start is a single-cycle pulse
      o_start <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (i_req) begin
            o_start <= 1'b1;
            state_q <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (i_finish) begin
            state_q <= ST_ACK;
          end
        end
        ST_ACK: begin
          // Hold ack until the processor lets go of req
          if (!i_req) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Access latched at acceptance, read word at finish
  always_ff @(posedge i_clk) begin
    if (state_q == ST_IDLE && i_req) begin
      o_addr  <= i_addr;
      o_wdata <= i_wdata;
      o_size  <= i_size;
      o_write <= i_write;
    end
    if (state_q == ST_BUSY && i_finish) begin
      o_rdata <= i_word;
    end
  end

  // Ack straight from the state register
  assign o_ack = (state_q == ST_ACK);

endmodule

//--- hw/mem_bus_pkg.sv
package mem_bus_pkg;

  // Byte address and bus word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Payload of one byte transfer
  typedef logic [7:0] byte_t;

  // Access size, 1, 2 or 4 byte transfers
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // Memory map
  localparam addr_t RAM_BASE  = 32'h0000_0000;
  localparam addr_t REGS_BASE = 32'h0001_0000;

  // Status bank is 8 bytes, so 3 offset bits
  localparam int unsigned REGS_ADDR_W = 3;

  // Last byte lane an access touches
  function automatic logic [1:0] size_last_lane(size_e size);
    case (size)
      SIZE_HALF: return 2'd1;
      SIZE_WORD: return 2'd3;
      // Byte, and the unused encoding
      default:   return 2'd0;
    endcase
  endfunction

endpackage
